// ==== logic/lb_pkg.sv ====
//----------------------------------------------------------
// Loopback hub shared definitions
// Message types, body field positions and message vectors
//----------------------------------------------------------
package lb_pkg;

  localparam int MSG_TYPE_WIDTH = 4;
  localparam int DESC_WIDTH     = 32;

  // Body fields
  localparam int DEST_CORE_LSB = 24;
  localparam int SLOT_LSB      = 16;

  typedef logic [MSG_TYPE_WIDTH+DESC_WIDTH-1:0] ctrl_msg_t;
  typedef logic [DESC_WIDTH-1:0]                desc_t;

  typedef enum logic [MSG_TYPE_WIDTH-1:0] {
    MSG_SLOT_RETURN  = 4'd0,
    MSG_PKT_DONE     = 4'd1,
    MSG_LOOPBACK_REQ = 4'd2,
    MSG_SLOT_INIT    = 4'd3
  } msg_type_e;

  // Reply types reuse the same encoding space
  localparam msg_type_e MSG_SEND_OUT = MSG_SLOT_RETURN;
  localparam msg_type_e MSG_LOOPBACK = MSG_PKT_DONE;

endpackage

// ==== logic/lb_msg_decoder.sv ====
//----------------------------------------------------------
// Control message decoder
// Registers core messages, splits them by type into FIFO
// writes and slot pool strobes, applies back-pressure
//----------------------------------------------------------
`timescale 1ns/1ps

module lb_msg_decoder #(
  parameter int  CORE_COUNT = 4,
  parameter int  SLOT_COUNT = 8,
  localparam int CORE_W     = $clog2(CORE_COUNT),
  localparam int SLOT_W     = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  lb_pkg::ctrl_msg_t     ctrl_in_data,
  input  logic [CORE_W-1:0]     ctrl_in_src,
  input  logic                  ctrl_in_valid,
  output logic                  ctrl_in_ready,
  output logic                  done_wr,
  input  logic                  done_ready,
  output logic [CORE_COUNT-1:0] loop_wr,
  input  logic [CORE_COUNT-1:0] loop_ready,
  output lb_pkg::desc_t         body,
  output logic [CORE_W-1:0]     src,
  output logic [CORE_COUNT-1:0] slot_return,
  output logic [CORE_COUNT-1:0] slot_init,
  output logic [SLOT_W-1:0]     slot_value
);
  import lb_pkg::*;

  ctrl_msg_t         in_msg;
  logic              in_valid;
  msg_type_e         in_type;
  logic [CORE_W-1:0] dest;
  logic              sink_ok;
  logic              accept;

  assign in_type = msg_type_e'(in_msg[DESC_WIDTH +: MSG_TYPE_WIDTH]);
  assign dest    = in_msg[DEST_CORE_LSB +: CORE_W];
  assign body    = in_msg[DESC_WIDTH-1:0];

  // Slot returns and inits never stall
  always_comb begin
    case (in_type)
      MSG_PKT_DONE:     sink_ok = done_ready;
      MSG_LOOPBACK_REQ: sink_ok = loop_ready[dest];
      default:          sink_ok = 1'b1;
    endcase
  end

  assign accept        = in_valid && sink_ok;
  assign ctrl_in_ready = !in_valid || sink_ok;
  assign done_wr       = accept && (in_type == MSG_PKT_DONE);
  assign loop_wr = {{(CORE_COUNT-1){1'b0}}, accept && (in_type == MSG_LOOPBACK_REQ)} << dest;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_valid <= 1'b0;
    end else if (ctrl_in_ready) begin
      in_valid <= ctrl_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_in_ready && ctrl_in_valid) begin
      in_msg <= ctrl_in_data;
      src    <= ctrl_in_src;
    end
  end

  // Pool updates go out one cycle later, steered by sender
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_return <= '0;
      slot_init   <= '0;
    end else begin
      slot_return <= {{(CORE_COUNT-1){1'b0}}, accept && (in_type == MSG_SLOT_RETURN)} << src;
      slot_init   <= {{(CORE_COUNT-1){1'b0}}, accept && (in_type == MSG_SLOT_INIT)} << src;
    end
  end

  always_ff @(posedge clk) begin
    slot_value <= in_msg[SLOT_LSB +: SLOT_W];
  end

  assert property (@(posedge clk) disable iff (rst)
    in_valid |-> in_type inside {MSG_SLOT_RETURN, MSG_PKT_DONE, MSG_LOOPBACK_REQ, MSG_SLOT_INIT});

endmodule

// ==== logic/desc_fifo.sv ====
//----------------------------------------------------------
// Descriptor FIFO
// Synchronous FIFO of message bodies tagged with the
// sending core
//----------------------------------------------------------
`timescale 1ns/1ps

module desc_fifo #(
  parameter int  CORE_COUNT      = 4,
  parameter int  FIFO_DEPTH_LOG2 = 3,
  localparam int CORE_W          = $clog2(CORE_COUNT),
  localparam int WIDTH           = CORE_W + lb_pkg::DESC_WIDTH
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr,
  input  logic [WIDTH-1:0] din,
  output logic             full_n,
  input  logic             rd,
  output logic [WIDTH-1:0] dout,
  output logic             not_empty
);
  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

  logic [WIDTH-1:0]         mem [DEPTH];
  // One extra pointer bit separates full from empty
  logic [FIFO_DEPTH_LOG2:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0] fill;

  assign fill      = wr_ptr - rd_ptr;
  assign full_n    = fill != (FIFO_DEPTH_LOG2 + 1)'(DEPTH);
  assign not_empty = fill != '0;
  assign dout      = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) wr |-> full_n);
  assert property (@(posedge clk) disable iff (rst) rd |-> not_empty);

endmodule

// ==== logic/slot_keeper.sv ====
//----------------------------------------------------------
// Slot keeper
// Pool of free packet slot numbers for one core, with
// refill, return, pop and occupancy count
//----------------------------------------------------------
`timescale 1ns/1ps

module slot_keeper #(
  parameter int  SLOT_COUNT = 8,
  localparam int SLOT_W     = $clog2(SLOT_COUNT + 1),
  localparam int IDX_W      = $clog2(SLOT_COUNT)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              init,
  input  logic [SLOT_W-1:0] init_count,
  input  logic              slot_return,
  input  logic [SLOT_W-1:0] slot_in,
  input  logic              pop,
  output logic [SLOT_W-1:0] slot_out,
  output logic              slot_available,
  output logic [SLOT_W-1:0] slot_count
);
  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [IDX_W-1:0]  idx_t;

  slot_t pool [SLOT_COUNT];
  idx_t  head;
  idx_t  tail;
  logic  do_pop;

  function automatic idx_t step(idx_t p);
    return (p == idx_t'(SLOT_COUNT - 1)) ? '0 : p + 1'b1;
  endfunction

  assign slot_out       = pool[head];
  assign slot_available = slot_count != '0;
  // Popping an empty pool is ignored
  assign do_pop         = pop && slot_available;

  // Init lays out slots 1..N from the bottom
  always_ff @(posedge clk) begin
    if (init) begin
      for (int i = 0; i < SLOT_COUNT; i++) begin
        pool[i] <= slot_t'(i + 1);
      end
    end else if (slot_return) begin
      pool[tail] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head       <= '0;
      tail       <= '0;
      slot_count <= '0;
    end else if (init) begin
      head       <= '0;
      tail       <= (init_count >= slot_t'(SLOT_COUNT)) ? '0 : idx_t'(init_count);
      slot_count <= init_count;
    end else begin
      if (slot_return) begin
        tail <= step(tail);
      end
      if (do_pop) begin
        head <= step(head);
      end
      slot_count <= slot_count + slot_t'(slot_return) - slot_t'(do_pop);
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    slot_return && !init |-> (slot_count < slot_t'(SLOT_COUNT)) || do_pop);

endmodule

// ==== logic/core_req_arbiter.sv ====
//----------------------------------------------------------
// Loopback request arbiter
// Round-robin over per-core queues whose target core is
// enabled and has a free slot, holds the grant until taken
//----------------------------------------------------------
`timescale 1ns/1ps

module core_req_arbiter #(
  parameter int  CORE_COUNT = 4,
  parameter int  SLOT_COUNT = 8,
  localparam int CORE_W     = $clog2(CORE_COUNT),
  localparam int SLOT_W     = $clog2(SLOT_COUNT + 1)
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic [CORE_COUNT-1:0]                   req_valid,
  input  logic [CORE_COUNT*CORE_W-1:0]            req_src,
  input  logic [CORE_COUNT*lb_pkg::DESC_WIDTH-1:0] req_body,
  output logic [CORE_COUNT-1:0]                   req_pop,
  input  logic [CORE_COUNT-1:0]                   slot_ok,
  input  logic [CORE_COUNT-1:0]                   enabled,
  input  logic [CORE_COUNT-1:0]                   host_pop_mask,
  input  logic [CORE_COUNT*SLOT_W-1:0]            slot_heads,
  output logic [CORE_COUNT-1:0]                   slot_take,
  output logic                                    grant_valid,
  output logic [CORE_W-1:0]                       grant_src,
  output lb_pkg::desc_t                           grant_body,
  output logic [SLOT_W-1:0]                       grant_slot,
  input  logic                                    grant_ready
);
  import lb_pkg::*;

  typedef logic [CORE_W-1:0] core_t;

  logic [CORE_COUNT-1:0] eligible;
  core_t                 rr_ptr;
  core_t                 winner;
  logic                  found;
  logic                  fire;

  // Host pop has priority on its core this cycle
  assign eligible = req_valid & slot_ok & enabled & ~host_pop_mask;

  // First eligible core at or after the pointer
  always_comb begin
    winner = rr_ptr;
    found  = 1'b0;
    for (int k = 0; k < CORE_COUNT; k++) begin
      core_t idx;
      idx = core_t'((int'(rr_ptr) + k) % CORE_COUNT);
      if (!found && eligible[idx]) begin
        winner = idx;
        found  = 1'b1;
      end
    end
  end

  assign fire      = found && (!grant_valid || grant_ready);
  assign req_pop   = {{(CORE_COUNT-1){1'b0}}, fire} << winner;
  assign slot_take = req_pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_valid <= 1'b0;
      rr_ptr      <= '0;
    end else if (fire) begin
      grant_valid <= 1'b1;
      rr_ptr      <= (winner == core_t'(CORE_COUNT - 1)) ? '0 : winner + 1'b1;
    end else if (grant_ready) begin
      grant_valid <= 1'b0;
    end
  end

  // Slot head is captured on the same edge the keeper pops it
  always_ff @(posedge clk) begin
    if (fire) begin
      grant_src  <= req_src[winner*CORE_W +: CORE_W];
      grant_body <= req_body[winner*DESC_WIDTH +: DESC_WIDTH];
      grant_slot <= slot_heads[winner*SLOT_W +: SLOT_W];
    end
  end

endmodule

// ==== logic/lb_ctrl_out.sv ====
//----------------------------------------------------------
// Reply output stage
// Fair merge of send-out and loopback replies, reply
// formatting, loopback port rotation and output register
//----------------------------------------------------------
`timescale 1ns/1ps

module lb_ctrl_out #(
  parameter int  CORE_COUNT     = 4,
  parameter int  SLOT_COUNT     = 8,
  parameter int  LOOPBACK_PORT  = 3,
  parameter int  LOOPBACK_COUNT = 2,
  localparam int CORE_W         = $clog2(CORE_COUNT),
  localparam int SLOT_W         = $clog2(SLOT_COUNT + 1),
  localparam int OFF_W          = (LOOPBACK_COUNT > 1) ? $clog2(LOOPBACK_COUNT) : 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              loop_valid,
  input  logic [CORE_W-1:0] loop_src,
  input  lb_pkg::desc_t     loop_body,
  input  logic [SLOT_W-1:0] loop_slot,
  output logic              loop_ready,
  input  logic              done_valid,
  input  logic [CORE_W-1:0] done_src,
  input  lb_pkg::desc_t     done_body,
  output logic              done_ready,
  output lb_pkg::ctrl_msg_t ctrl_out_data,
  output logic [CORE_W-1:0] ctrl_out_dest,
  output logic              ctrl_out_valid,
  input  logic              ctrl_out_ready
);
  import lb_pkg::*;

  logic             out_free;
  logic             last_loop;
  logic             sel_loop;
  logic             take_loop;
  logic             take_done;
  logic [OFF_W-1:0] port_off;
  desc_t            loop_reply;

  assign out_free  = !ctrl_out_valid || ctrl_out_ready;
  // Alternate when both sides are waiting
  assign sel_loop  = loop_valid && (!done_valid || !last_loop);
  assign take_loop = out_free && sel_loop;
  assign take_done = out_free && done_valid && !sel_loop;

  assign loop_ready = take_loop;
  assign done_ready = take_done;

  // Port, source slot, then destination core and slot
  always_comb begin
    loop_reply                         = '0;
    loop_reply[DEST_CORE_LSB +: 8]     = 8'(LOOPBACK_PORT + port_off);
    loop_reply[SLOT_LSB +: 8]          = loop_body[SLOT_LSB +: 8];
    loop_reply[SLOT_W +: CORE_W]       = loop_body[DEST_CORE_LSB +: CORE_W];
    loop_reply[SLOT_W-1:0]             = loop_slot;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_out_valid <= 1'b0;
      last_loop      <= 1'b0;
      port_off       <= '0;
    end else begin
      if (out_free) begin
        ctrl_out_valid <= take_loop || take_done;
      end
      if (take_loop || take_done) begin
        last_loop <= take_loop;
      end
      if (take_loop) begin
        port_off <= (port_off == OFF_W'(LOOPBACK_COUNT - 1)) ? '0 : port_off + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_loop) begin
      ctrl_out_data <= {MSG_LOOPBACK, loop_reply};
      ctrl_out_dest <= loop_src;
    end else if (take_done) begin
      ctrl_out_data <= {MSG_SEND_OUT, done_body};
      ctrl_out_dest <= done_src;
    end
  end

  // Both sources hold their item until this stage takes it
  assert property (@(posedge clk) disable iff (rst)
    loop_valid && !loop_ready |=>
      loop_valid && $stable(loop_src) && $stable(loop_body) && $stable(loop_slot));

  assert property (@(posedge clk) disable iff (rst)
    done_valid && !done_ready |=> done_valid && $stable(done_src) && $stable(done_body));

endmodule

// ==== logic/lb_controller.sv ====
//----------------------------------------------------------
// Loopback control hub
// Core control messages in, send-out and loopback
// replies out, per-core slot pools with host access
//----------------------------------------------------------
`timescale 1ns/1ps

module lb_controller #(
  parameter int  CORE_COUNT      = 4,
  parameter int  SLOT_COUNT      = 8,
  parameter int  LOOPBACK_PORT   = 3,
  parameter int  LOOPBACK_COUNT  = 2,
  parameter int  FIFO_DEPTH_LOG2 = 3,
  localparam int CORE_W          = $clog2(CORE_COUNT),
  localparam int SLOT_W          = $clog2(SLOT_COUNT + 1)
) (
  input  logic                         clk,
  input  logic                         rst,
  input  lb_pkg::ctrl_msg_t            ctrl_in_data,
  input  logic [CORE_W-1:0]            ctrl_in_src,
  input  logic                         ctrl_in_valid,
  output logic                         ctrl_in_ready,
  output lb_pkg::ctrl_msg_t            ctrl_out_data,
  output logic [CORE_W-1:0]            ctrl_out_dest,
  output logic                         ctrl_out_valid,
  input  logic                         ctrl_out_ready,
  input  logic [CORE_COUNT-1:0]        enabled_cores,
  input  logic [CORE_COUNT-1:0]        slots_flush,
  output logic [CORE_COUNT*SLOT_W-1:0] slot_counts,
  output logic [CORE_COUNT-1:0]        slot_valids,
  output logic [CORE_COUNT-1:0]        slots_busy,
  input  logic [CORE_W-1:0]            selected_core,
  input  logic                         rx_desc_pop,
  output logic [CORE_W+SLOT_W-1:0]     rx_desc_data
);
  import lb_pkg::*;

  desc_t                           body;
  logic [CORE_W-1:0]               src;
  logic                            done_wr;
  logic                            done_ready;
  logic [CORE_COUNT-1:0]           loop_wr;
  logic [CORE_COUNT-1:0]           loop_ready;
  logic [CORE_COUNT-1:0]           slot_return;
  logic [CORE_COUNT-1:0]           slot_init;
  logic [SLOT_W-1:0]               slot_value;
  logic                            done_valid;
  logic [CORE_W-1:0]               done_src;
  desc_t                           done_body;
  logic                            done_rd;
  logic [CORE_COUNT-1:0]           req_valid;
  logic [CORE_COUNT*CORE_W-1:0]    req_src;
  logic [CORE_COUNT*DESC_WIDTH-1:0] req_body;
  logic [CORE_COUNT-1:0]           req_pop;
  logic [CORE_COUNT*SLOT_W-1:0]    slot_heads;
  logic [CORE_COUNT-1:0]           slot_take;
  logic [CORE_COUNT-1:0]           host_pop;
  logic                            grant_valid;
  logic [CORE_W-1:0]               grant_src;
  desc_t                           grant_body;
  logic [SLOT_W-1:0]               grant_slot;
  logic                            grant_ready;

  assign slots_busy   = slot_take;
  assign rx_desc_data = {selected_core, slot_heads[selected_core*SLOT_W +: SLOT_W]};

  lb_msg_decoder #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) decoder_i (
    .clk(clk), .rst(rst),
    .ctrl_in_data(ctrl_in_data), .ctrl_in_src(ctrl_in_src),
    .ctrl_in_valid(ctrl_in_valid), .ctrl_in_ready(ctrl_in_ready),
    .done_wr(done_wr), .done_ready(done_ready),
    .loop_wr(loop_wr), .loop_ready(loop_ready),
    .body(body), .src(src),
    .slot_return(slot_return), .slot_init(slot_init), .slot_value(slot_value)
  );

  desc_fifo #(.CORE_COUNT(CORE_COUNT), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) done_fifo_i (
    .clk(clk), .rst(rst),
    .wr(done_wr), .din({src, body}), .full_n(done_ready),
    .rd(done_rd), .dout({done_src, done_body}), .not_empty(done_valid)
  );

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core
    assign host_pop[i] = rx_desc_pop && (selected_core == CORE_W'(i));

    // Loopback requests queued by target core
    desc_fifo #(.CORE_COUNT(CORE_COUNT), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) loop_fifo_i (
      .clk(clk), .rst(rst),
      .wr(loop_wr[i]), .din({src, body}), .full_n(loop_ready[i]),
      .rd(req_pop[i]),
      .dout({req_src[i*CORE_W +: CORE_W], req_body[i*DESC_WIDTH +: DESC_WIDTH]}),
      .not_empty(req_valid[i])
    );

    slot_keeper #(.SLOT_COUNT(SLOT_COUNT)) keeper_i (
      .clk(clk), .rst(rst || slots_flush[i]),
      .init(slot_init[i]), .init_count(slot_value),
      .slot_return(slot_return[i]), .slot_in(slot_value),
      .pop(slot_take[i] || host_pop[i]),
      .slot_out(slot_heads[i*SLOT_W +: SLOT_W]),
      .slot_available(slot_valids[i]),
      .slot_count(slot_counts[i*SLOT_W +: SLOT_W])
    );
  end

  core_req_arbiter #(.CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT)) arbiter_i (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_src(req_src), .req_body(req_body), .req_pop(req_pop),
    .slot_ok(slot_valids), .enabled(enabled_cores), .host_pop_mask(host_pop),
    .slot_heads(slot_heads), .slot_take(slot_take),
    .grant_valid(grant_valid), .grant_src(grant_src), .grant_body(grant_body),
    .grant_slot(grant_slot), .grant_ready(grant_ready)
  );

  lb_ctrl_out #(
    .CORE_COUNT(CORE_COUNT), .SLOT_COUNT(SLOT_COUNT),
    .LOOPBACK_PORT(LOOPBACK_PORT), .LOOPBACK_COUNT(LOOPBACK_COUNT)
  ) out_i (
    .clk(clk), .rst(rst),
    .loop_valid(grant_valid), .loop_src(grant_src), .loop_body(grant_body),
    .loop_slot(grant_slot), .loop_ready(grant_ready),
    .done_valid(done_valid), .done_src(done_src), .done_body(done_body),
    .done_ready(done_rd),
    .ctrl_out_data(ctrl_out_data), .ctrl_out_dest(ctrl_out_dest),
    .ctrl_out_valid(ctrl_out_valid), .ctrl_out_ready(ctrl_out_ready)
  );

endmodule

// ==== tb/lb_controller_tb.sv ====
//----------------------------------------------------------
// Loopback hub testbench
// Random core traffic checked against a slot pool and
// reply model, with host pops, flush and back-pressure
//----------------------------------------------------------
`timescale 1ns/1ps

module lb_controller_tb;
  import lb_pkg::*;

  localparam int  CORES = 4;
  localparam int  SLOTS = 8;
  localparam int  CW    = $clog2(CORES);
  localparam int  SW    = $clog2(SLOTS + 1);
  localparam int  ITEMS = 64;
  localparam time CLK_PERIOD = 100ns;

  typedef logic [CW-1:0] core_t;
  typedef logic [SW-1:0] count_t;

  logic clk, rst;
  ctrl_msg_t ctrl_in_data, ctrl_out_data;
  core_t ctrl_in_src, ctrl_out_dest, selected_core;
  logic ctrl_in_valid, ctrl_in_ready, ctrl_out_valid, ctrl_out_ready, rx_desc_pop;
  logic [CORES-1:0] enabled_cores, slots_flush, slot_valids, slots_busy;
  logic [CORES*SW-1:0] slot_counts;
  logic [CW+SW-1:0] rx_desc_data;

  // Model state
  int slotq[CORES][$];
  int done_q[CORES][$];
  int pend_q[CORES][$];
  int grant_cnt[CORES];
  int port_off;
  int errors;
  logic rand_ready;
  logic prev_stall;
  ctrl_msg_t prev_data;

  lb_controller #(
    .CORE_COUNT(CORES), .SLOT_COUNT(SLOTS), .LOOPBACK_PORT(3), .LOOPBACK_COUNT(2)
  ) lb_controller_i (
    .clk(clk), .rst(rst),
    .ctrl_in_data(ctrl_in_data), .ctrl_in_src(ctrl_in_src),
    .ctrl_in_valid(ctrl_in_valid), .ctrl_in_ready(ctrl_in_ready),
    .ctrl_out_data(ctrl_out_data), .ctrl_out_dest(ctrl_out_dest),
    .ctrl_out_valid(ctrl_out_valid), .ctrl_out_ready(ctrl_out_ready),
    .enabled_cores(enabled_cores), .slots_flush(slots_flush),
    .slot_counts(slot_counts), .slot_valids(slot_valids), .slots_busy(slots_busy),
    .selected_core(selected_core), .rx_desc_pop(rx_desc_pop), .rx_desc_data(rx_desc_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_msg(string name, ctrl_msg_t exp, ctrl_msg_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_dest(string name, core_t exp, core_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_count(string name, count_t exp, count_t act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Loopback reply with port and source slot, then dest core and slot at the bottom
  function automatic ctrl_msg_t loop_reply(int port, int src_slot, int core, int slot);
    ctrl_msg_t m;
    m = '0;
    m[DESC_WIDTH +: MSG_TYPE_WIDTH] = 4'd1;
    m[DEST_CORE_LSB +: 8] = 8'(port);
    m[SLOT_LSB +: 8] = 8'(src_slot);
    m[SW +: CW] = CW'(core);
    m[SW-1:0] = SW'(slot);
    return m;
  endfunction

  task automatic send_msg(int mtype, int src, logic [31:0] body_val);
    @(negedge clk);
    ctrl_in_data  = {4'(mtype), body_val};
    ctrl_in_src   = core_t'(src);
    ctrl_in_valid = 1'b1;
    @(posedge clk);
    while (!ctrl_in_ready) @(posedge clk);
    @(negedge clk);
    ctrl_in_valid = 1'b0;
  endtask

  task automatic check_counts(string name);
    repeat (4) @(negedge clk);
    for (int c = 0; c < CORES; c++) begin
      compare_count(name, count_t'(slotq[c].size()), slot_counts[c*SW +: SW]);
      compare_count({name, " valid"}, count_t'(slotq[c].size() != 0),
                    count_t'(slot_valids[c]));
    end
  endtask

  task automatic check_reply();
    int d, s;
    ctrl_msg_t exp;
    if (ctrl_out_data[35:32] == 4'd0) begin
      s = ctrl_out_data[31:30];
      if (done_q[s].size() == 0) begin
        errors++;
        $display("Unexpected send-out reply for core %0d", s);
      end else begin
        compare_msg("send_out", {4'd0, 32'(done_q[s].pop_front())}, ctrl_out_data);
        compare_dest("send_out dest", core_t'(s), ctrl_out_dest);
      end
    end else if (ctrl_out_data[35:32] == 4'd1) begin
      d = ctrl_out_data[SW +: CW];
      if (!enabled_cores[d] || pend_q[d].size() == 0 || slotq[d].size() == 0 ||
          grant_cnt[d] == 0) begin
        errors++;
        $display("Unexpected loopback reply toward core %0d", d);
      end else begin
        grant_cnt[d]--;
        s = pend_q[d].pop_front();
        exp = loop_reply(3 + port_off, s & 8'hff, d, slotq[d].pop_front());
        compare_msg("loopback", exp, ctrl_out_data);
        compare_dest("loopback dest", core_t'(s >> 8), ctrl_out_dest);
        port_off = (port_off + 1) % 2;
      end
    end else begin
      errors++;
      $display("Reply with unknown type %0d", ctrl_out_data[35:32]);
    end
  endtask

  // Reply monitor, slot grant tally and hold check under stall
  always @(posedge clk) begin
    if (!rst) begin
      for (int c = 0; c < CORES; c++) begin
        if (slots_busy[c]) grant_cnt[c]++;
      end
      if (prev_stall) compare_msg("hold", prev_data, ctrl_out_data);
      if (ctrl_out_valid && ctrl_out_ready) check_reply();
      prev_stall = ctrl_out_valid && !ctrl_out_ready;
      prev_data  = ctrl_out_data;
    end
  end

  always @(negedge clk) begin
    ctrl_out_ready = rand_ready ? ($urandom % 4 != 0) : 1'b1;
  end

  initial begin
    #(ITEMS * 200 * CLK_PERIOD);
    $display("Watchdog expired with replies still outstanding");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int n, t, s, busy;
    void'($urandom(32'hbf74));
    errors = 0;
    port_off = 0;
    rand_ready = 1'b0;
    prev_stall = 1'b0;
    rst = 1'b1;
    ctrl_in_data = '0;
    ctrl_in_src = '0;
    ctrl_in_valid = 1'b0;
    ctrl_out_ready = 1'b1;
    enabled_cores = '1;
    slots_flush = '0;
    selected_core = '0;
    rx_desc_pop = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Pool init, then returns into non-full pools
    for (int c = 0; c < CORES; c++) begin
      n = 1 + $urandom % SLOTS;
      send_msg(3, c, 32'(n) << SLOT_LSB);
      slotq[c].delete();
      for (int k = 1; k <= n; k++) slotq[c].push_back(k);
    end
    check_counts("init");
    for (int i = 0; i < 8; i++) begin
      t = $urandom % CORES;
      s = 1 + $urandom % SLOTS;
      if (slotq[t].size() < SLOTS) begin
        send_msg(0, t, 32'(s) << SLOT_LSB);
        slotq[t].push_back(s);
      end
    end
    check_counts("return");

    // Host view and pop of each nonempty pool
    for (int c = 0; c < CORES; c++) begin
      @(negedge clk);
      selected_core = core_t'(c);
      @(negedge clk);
      if (slotq[c].size() != 0) begin
        compare_dest("host_view core", core_t'(c), rx_desc_data[CW+SW-1:SW]);
        compare_count("host_view slot", count_t'(slotq[c][0]), rx_desc_data[SW-1:0]);
        rx_desc_pop = 1'b1;
        @(negedge clk);
        rx_desc_pop = 1'b0;
        void'(slotq[c].pop_front());
      end
    end
    check_counts("host_pop");

    // Mixed traffic with core 3 disabled and random output stalls
    enabled_cores = 4'b0111;
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      s = $urandom % CORES;
      t = $urandom % CORES;
      if ($urandom % 2 || pend_q[t].size() >= slotq[t].size()) begin
        n = {s[1:0], 30'($urandom)};
        done_q[s].push_back(n);
        send_msg(1, s, 32'(n));
      end else begin
        n = $urandom % 256;
        pend_q[t].push_back((s << 8) | n);
        send_msg(2, s, (32'(t) << DEST_CORE_LSB) | (32'(n) << SLOT_LSB));
      end
    end
    repeat (100) @(negedge clk);
    compare_count("disabled", count_t'(slotq[3].size()), slot_counts[3*SW +: SW]);
    enabled_cores = '1;
    do begin
      @(negedge clk);
      busy = 0;
      for (int c = 0; c < CORES; c++) busy += done_q[c].size() + pend_q[c].size();
    end while (busy != 0);
    rand_ready = 1'b0;
    for (int c = 0; c < CORES; c++) begin
      if (grant_cnt[c] != 0) begin
        errors++;
        $display("Slot grant on core %0d without a loopback reply", c);
      end
    end
    check_counts("loopback");

    // Flush of core 0
    @(negedge clk);
    slots_flush = 4'b0001;
    @(negedge clk);
    slots_flush = '0;
    slotq[0].delete();
    check_counts("flush");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/lb_pkg.sv
logic/lb_msg_decoder.sv
logic/desc_fifo.sv
logic/slot_keeper.sv
logic/core_req_arbiter.sv
logic/lb_ctrl_out.sv
logic/lb_controller.sv
tb/lb_controller_tb.sv
